// File: Makefile
# Verilator build, run and lint for the EX1 stage
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
FILELIST ?= src.f
TB_TOP ?= ex1Tb
RTL_TOP ?= ex1Stage
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/ex1Agu.sv
/* address generation for EX1: load/store address and branch target
   jump-quad flag is sr bit 31 from the previous cycle */
`timescale 1ns/1ns
`default_nettype none
`include "ex1_cfg.svh"

module ex1Agu (
	input logic clock,
	input logic rst,
	ex1OperandIf.reader ops,
	output logic [`EX1_VADDR_W-1:0] memAddr,
	output logic [`EX1_DATA_W-1:0] braTarget
);
	logic flagJq;
	// displacement scaled to bytes
	logic [`EX1_VADDR_W-1:0] dispSc;
	logic [`EX1_LOW_W:0] lowSum;
	logic [`EX1_VADDR_W-`EX1_LOW_W-1:0] hiSum;
	logic [`EX1_VADDR_W-`EX1_LOW_W-1:0] hiSel;

	// base plus index, index scaled by access size in ixt[5:4]
	assign memAddr = ops.valRs[`EX1_VADDR_W-1:0] +
		(ops.valRt[`EX1_VADDR_W-1:0] << ops.ixt[5:4]);

	// branch displacement counts 16-bit units
	assign dispSc = {ops.valRt[`EX1_VADDR_W-2:0], 1'b0};

	// low add, carry out feeds the upper part
	assign lowSum = {1'b0, ops.pc[`EX1_LOW_W-1:0]} + {1'b0, dispSc[`EX1_LOW_W-1:0]};
	assign hiSum = ops.pc[`EX1_VADDR_W-1:`EX1_LOW_W] +
		dispSc[`EX1_VADDR_W-1:`EX1_LOW_W] +
		{{(`EX1_VADDR_W-`EX1_LOW_W-1){1'b0}}, lowSum[`EX1_LOW_W]};

	// no jump-quad, keep the pc's upper address bits
	assign hiSel = flagJq ? hiSum : ops.pc[`EX1_VADDR_W-1:`EX1_LOW_W];

	// bits above the vaddr always follow the pc
	assign braTarget = {ops.pc[`EX1_DATA_W-1:`EX1_VADDR_W], hiSel,
		lowSum[`EX1_LOW_W-1:0]};

	always_ff @(posedge clock) begin
		if (rst) begin
			flagJq <= 1'b0;
		end else begin
			flagJq <= ops.srJq;
		end
	end

	// flag must come up clear right out of reset
	assert property (@(posedge clock) rst |=> !flagJq);

endmodule

`default_nettype wire

// File: design/ex1BranchUnit.sv
/* branch resolution in EX1: checks BRA, BRA_NB, BSR, JMP and JSR
   against the front end guess, and writes LR for the calls */
`timescale 1ns/1ns
`default_nettype none
`include "ex1_cfg.svh"

module ex1BranchUnit import ex1Pkg::*; (
	ex1OperandIf.reader ops,
	input logic [`EX1_DATA_W-1:0] aguTarget,
	input preBraE preBra,
	ex1ResultIf.unit res
);
	always_comb begin
		res.claim = 1'b0;
		res.doBra = 1'b0;
		res.braTarget = aguTarget;
		res.lrWrite = 1'b0;
		case (ops.uCmd)
			UCMD_BRA_NB: begin
				res.claim = 1'b1;
				// predicated off but fetched down the target, go back to pc
				res.doBra = (preBra != PRE_NONE);
				res.braTarget = ops.pc;
			end
			UCMD_BRA, UCMD_BSR: begin
				res.claim = 1'b1;
				// already taken by the front end, nothing to redirect
				res.doBra = (preBra != PRE_TAKEN);
				res.lrWrite = (ops.uCmd == UCMD_BSR);
			end
			UCMD_JMP: begin
				res.claim = 1'b1;
				res.doBra = (preBra != PRE_TAKEN);
				res.braTarget = {ops.pc[`EX1_DATA_W-1:`EX1_VADDR_W],
					ops.valRs[`EX1_VADDR_W-1:0]};
			end
			UCMD_JSR: begin
				res.claim = 1'b1;
				// register call is never predicted
				res.doBra = 1'b1;
				res.braTarget = ops.valRs;
				res.lrWrite = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// return address is the pc of the next op
	assign res.lrValue = ops.pc;

	// no results, sr, traps or memory from this unit
	assign res.resultValid = 1'b0;
	assign res.resultValue = '0;
	assign res.srWrite = 1'b0;
	assign res.srValue = {ops.srS, ops.srT};
	assign res.trapValid = 1'b0;
	assign res.trapCode = '0;
	assign res.memReq = 1'b0;
	assign res.memOpm = OPM_READY;
	assign res.hold = 1'b0;

	// a redirect only ever comes from a branch this unit owns
	assert property (@(posedge ops.clock) res.doBra |-> res.claim);

endmodule

`default_nettype wire

// File: design/ex1Dispatch.sv
/* EX1 dispatch: predication, main opcode decode, memory issue,
   and merge of the branch and system unit results into stage outputs */
`timescale 1ns/1ns
`default_nettype none
`include "ex1_cfg.svh"

module ex1Dispatch import ex1Pkg::*; (
	input logic [`EX1_CMD_W-1:0] opUCmd,
	input logic [`EX1_CMD_W-1:0] opUIxt,
	input logic braFlush,
	input logic [`EX1_DATA_W-1:0] srIn,
	input logic [`EX1_DATA_W-1:0] lrIn,
	input memOkE memDataOk,
	input logic [`EX1_VADDR_W-1:0] memAddrIn,
	ex1OperandIf.dispatch ops,
	ex1ResultIf.merge bra,
	ex1ResultIf.merge sys,
	output logic [`EX1_CMD_W-1:0] opUCmdOut,
	output logic [1:0] exHold,
	output logic [`EX1_REGID_W-1:0] regIdRn1,
	output logic [`EX1_DATA_W-1:0] regValRn1,
	output logic [`EX1_REGID_W-1:0] regIdCn1,
	output logic [`EX1_DATA_W-1:0] regValCn1,
	output logic [`EX1_REGID_W-1:0] heldIdRn1,
	output logic [`EX1_DATA_W-1:0] srOut,
	output logic [`EX1_DATA_W-1:0] lrOut,
	output logic [`EX1_VADDR_W-1:0] memAddr,
	output logic [4:0] memOpm,
	output logic [`EX1_DATA_W-1:0] memDataOut,
	output logic trapValid,
	output logic [`EX1_TRAP_W-1:0] trapOut
);
	logic opEnable;
	logic [`EX1_OPC_W-1:0] effCmd;
	// own decode
	logic localHit, localRes, localCr, localHeld, localMem, localTrap;
	logic [`EX1_DATA_W-1:0] localVal;
	logic [4:0] localOpm;

	// predication, flush wins over everything
	always_comb begin
		case (condE'(opUCmd[`EX1_CMD_W-1:`EX1_OPC_W]))
			CC_AL: opEnable = 1'b1;
			CC_NV: opEnable = 1'b0;
			CC_CT: opEnable = ops.srT;
			default: opEnable = !ops.srT;
		endcase
		if (braFlush) begin
			opEnable = 1'b0;
		end
	end

	// a disabled BRA still has to undo a front end guess
	assign effCmd = opEnable ? opUCmd[`EX1_OPC_W-1:0] :
		((opUCmd[`EX1_OPC_W-1:0] == UCMD_BRA && !braFlush) ? UCMD_BRA_NB : UCMD_NOP);
	assign ops.uCmd = uCmdE'(effCmd);
	assign opUCmdOut = {CC_AL, effCmd};

	always_comb begin
		localHit = 1'b1;
		localRes = 1'b0;
		localCr = 1'b0;
		localHeld = 1'b0;
		localMem = 1'b0;
		localTrap = 1'b0;
		localVal = ops.valRs;
		// direction, extension, size
		localOpm = {2'b01, opUIxt[2], opUIxt[5:4]};
		case (ops.uCmd)
			UCMD_NOP: begin
			end
			UCMD_INVOP: localTrap = 1'b1;
			UCMD_LEA_MR: begin
				localRes = 1'b1;
				localVal = {{(`EX1_DATA_W-`EX1_VADDR_W){1'b0}}, memAddrIn};
			end
			UCMD_MOV_RM: begin
				localMem = 1'b1;
				localOpm[4:3] = 2'b10;
			end
			// load data comes back in a later stage
			UCMD_MOV_MR: begin
				localMem = 1'b1;
				localHeld = 1'b1;
			end
			UCMD_ALU3, UCMD_MUL3, UCMD_CONV_RR: localHeld = 1'b1;
			// cr value arrives on the Rs operand
			UCMD_MOV_CR: localRes = 1'b1;
			UCMD_MOV_RC: begin
				localRes = 1'b1;
				localCr = 1'b1;
			end
			UCMD_MOV_IR: begin
				localRes = 1'b1;
				case (opUIxt[3:0])
					4'h1: localVal = {ops.valRs[55:0], ops.valRt[7:0]};
					4'h2: localVal = {ops.valRs[47:0], ops.valRt[15:0]};
					4'h3: localVal = {ops.valRs[31:0], ops.valRt[31:0]};
					// plain LDI, immediate already expanded into Rt
					default: localVal = ops.valRt;
				endcase
			end
			default: localHit = 1'b0;
		endcase
	end

	always_comb begin
		regIdRn1 = REG_ZZR;
		regValRn1 = localVal;
		regIdCn1 = REG_ZZR;
		regValCn1 = ops.valRs;
		heldIdRn1 = REG_ZZR;
		srOut = srIn;
		lrOut = lrIn;
		memAddr = memAddrIn;
		memOpm = OPM_READY;
		memDataOut = ops.valRm;
		trapValid = 1'b0;
		trapOut = '0;
		exHold = 2'b00;
		// single-cycle results land in Rm
		if (localRes) begin
			regIdRn1 = ops.idRm;
		end else if (bra.resultValid || sys.resultValid) begin
			regIdRn1 = ops.idRm;
			regValRn1 = bra.resultValid ? bra.resultValue : sys.resultValue;
		end
		if (localCr) begin
			regIdCn1 = ops.idRm;
			// a move into LR also refreshes the LR bypass
			if (ops.idRm == REG_LR) begin
				lrOut = ops.valRs;
			end
		end
		if (bra.lrWrite || sys.lrWrite) begin
			lrOut = bra.lrWrite ? bra.lrValue : sys.lrValue;
		end
		if (bra.srWrite || sys.srWrite) begin
			srOut[1:0] = bra.srWrite ? bra.srValue : sys.srValue;
		end
		// redirect goes out as a PC write
		if (bra.doBra || sys.doBra) begin
			regIdCn1 = REG_PC;
			regValCn1 = bra.doBra ? bra.braTarget : sys.braTarget;
		end
		if (localTrap) begin
			trapValid = 1'b1;
			trapOut = {ops.basePc, TRAP_INVOP};
		end else if (bra.trapValid || sys.trapValid) begin
			trapValid = 1'b1;
			trapOut = {ops.basePc, bra.trapValid ? bra.trapCode : sys.trapCode};
		end
		// same op is presented again while memory says HOLD
		if (localMem || bra.memReq || sys.memReq) begin
			memOpm = localMem ? localOpm : (bra.memReq ? bra.memOpm : sys.memOpm);
			if (memDataOk == MEM_HOLD) begin
				exHold[0] = 1'b1;
			end
		end
		// nobody owns this opcode
		if (!localHit && !bra.claim && !sys.claim) begin
			exHold[0] = 1'b1;
		end
		if (bra.hold || sys.hold) begin
			exHold[0] = 1'b1;
		end
		if (localHeld) begin
			exHold[1] = 1'b1;
			heldIdRn1 = ops.idRm;
		end
		if (braFlush) begin
			regIdRn1 = REG_ZZR;
			regIdCn1 = REG_ZZR;
		end
	end

	// opcode spaces of the two units must not overlap
	assert property (@(posedge ops.clock) !(bra.claim && sys.claim));

endmodule

`default_nettype wire

// File: design/ex1Ifs.sv
/* operand bundle fed to every EX1 unit, and the result bundle
   a unit hands back to dispatch for merging */
`timescale 1ns/1ns
`default_nettype none
`include "ex1_cfg.svh"

interface ex1OperandIf import ex1Pkg::*; (input logic clock);
	// effective command after predication
	uCmdE uCmd;
	logic [`EX1_OPC_W-1:0] ixt;
	logic [`EX1_REGID_W-1:0] idRs, idRt, idRm;
	logic [`EX1_DATA_W-1:0] valRs, valRt, valRm;
	logic [`EX1_DATA_W-1:0] pc;
	logic [`EX1_VADDR_W-1:0] basePc;
	// sr.t, sr.s and the jump-quad source bit
	logic srT, srS, srJq;

	modport reader (input clock, uCmd, ixt, idRs, idRt, idRm, valRs, valRt, valRm,
		pc, basePc, srT, srS, srJq);
	modport dispatch (input clock, ixt, idRs, idRt, idRm, valRs, valRt, valRm,
		pc, basePc, srT, srS, srJq, output uCmd);
endinterface

interface ex1ResultIf import ex1Pkg::*; ();
	logic claim;
	logic resultValid;
	logic [`EX1_DATA_W-1:0] resultValue;
	// low sr bits only, {s, t}
	logic srWrite;
	logic [1:0] srValue;
	logic lrWrite;
	logic [`EX1_DATA_W-1:0] lrValue;
	logic doBra;
	logic [`EX1_DATA_W-1:0] braTarget;
	logic trapValid;
	logic [`EX1_TRAPC_W-1:0] trapCode;
	logic memReq;
	memOpmE memOpm;
	logic hold;

	modport unit (output claim, resultValid, resultValue, srWrite, srValue, lrWrite,
		lrValue, doBra, braTarget, trapValid, trapCode, memReq, memOpm, hold);
	modport merge (input claim, resultValid, resultValue, srWrite, srValue, lrWrite,
		lrValue, doBra, braTarget, trapValid, trapCode, memReq, memOpm, hold);
endinterface

`default_nettype wire

// File: design/ex1Pkg.sv
/* shared types of the EX1 stage: opcodes, sub-ops, memory ops, register ids, trap codes */
`default_nettype none
`include "ex1_cfg.svh"

package ex1Pkg;
	// low six bits of opUCmd
	typedef enum logic [`EX1_OPC_W-1:0] {
		UCMD_NOP = 6'h00, UCMD_INVOP = 6'h01, UCMD_LEA_MR = 6'h02,
		UCMD_MOV_RM = 6'h03, UCMD_MOV_MR = 6'h04, UCMD_ALU3 = 6'h05,
		UCMD_MUL3 = 6'h06, UCMD_CONV_RR = 6'h07, UCMD_MOV_RC = 6'h08,
		UCMD_MOV_CR = 6'h09, UCMD_MOV_IR = 6'h0A, UCMD_BRA = 6'h0B,
		UCMD_BRA_NB = 6'h0C, UCMD_BSR = 6'h0D, UCMD_JMP = 6'h0E,
		UCMD_JSR = 6'h0F, UCMD_OP_IXS = 6'h10, UCMD_OP_IXT = 6'h11
	} uCmdE;

	// top two bits of opUCmd
	typedef enum logic [1:0] {CC_AL = 2'b00, CC_NV = 2'b01, CC_CT = 2'b10, CC_CF = 2'b11} condE;

	// sub-ops, carried in opUIxt[5:0]
	typedef enum logic [`EX1_OPC_W-1:0] {
		IXS_NOP = 6'h00, IXS_MOVT = 6'h01, IXS_MOVNT = 6'h02,
		IXS_MOVST = 6'h03, IXS_TRAPB = 6'h04
	} ixsE;

	typedef enum logic [`EX1_OPC_W-1:0] {
		IXT_NOP = 6'h00, IXT_SLEEP = 6'h01, IXT_BREAK = 6'h02,
		IXT_CLRT = 6'h03, IXT_SETT = 6'h04, IXT_CLRS = 6'h05,
		IXT_SETS = 6'h06, IXT_NOTT = 6'h07, IXT_NOTS = 6'h08,
		IXT_RTE = 6'h09, IXT_TRAPA = 6'h0A, IXT_SYSE = 6'h0B,
		IXT_LDTLB = 6'h0C, IXT_INVTLB = 6'h0D
	} ixtE;

	// front end guess for the branch in flight
	typedef enum logic [1:0] {PRE_NONE = 2'b00, PRE_TAKEN = 2'b01, PRE_OTHER = 2'b10} preBraE;

	// load is {2'b01, ext, size}, store {2'b10, ext, size}
	// system requests sit in the 11 space
	typedef enum logic [4:0] {
		OPM_READY = 5'b00000, OPM_TRAP = 5'b11001,
		OPM_LDTLB = 5'b11010, OPM_INVTLB = 5'b11011
	} memOpmE;

	typedef enum logic [1:0] {MEM_OK = 2'b00, MEM_HOLD = 2'b01} memOkE;

	// no destination
	localparam logic [`EX1_REGID_W-1:0] REG_ZZR = 6'h3F;
	localparam logic [`EX1_REGID_W-1:0] REG_LR = 6'h21;
	localparam logic [`EX1_REGID_W-1:0] REG_PC = 6'h20;

	// trap codes, TRAPA and SYSE get their low bits or'ed in
	localparam logic [`EX1_TRAPC_W-1:0] TRAP_INVOP = 16'h800E;
	localparam logic [`EX1_TRAPC_W-1:0] TRAP_RTE = 16'hFF00;
	localparam logic [`EX1_TRAPC_W-1:0] TRAP_TRAPA = 16'hC080;
	localparam logic [`EX1_TRAPC_W-1:0] TRAP_SYSE = 16'hE000;
endpackage

`default_nettype wire

// File: design/ex1Stage.sv
/* EX1 execute stage top level, plain ports toward the pipeline
   every output follows the current inputs in the same cycle */
`timescale 1ns/1ns
`default_nettype none
`include "ex1_cfg.svh"

module ex1Stage import ex1Pkg::*; (
	input logic clock,
	input logic rst,
	input logic [`EX1_CMD_W-1:0] opUCmd,
	input logic [`EX1_CMD_W-1:0] opUIxt,
	input preBraE preBra,
	input logic braFlush,
	input logic [`EX1_REGID_W-1:0] regIdRs, regIdRt, regIdRm,
	input logic [`EX1_DATA_W-1:0] regValRs, regValRt, regValRm,
	input logic [`EX1_DATA_W-1:0] pc,
	input logic [`EX1_VADDR_W-1:0] basePc,
	input logic [`EX1_DATA_W-1:0] srIn, lrIn, dlrIn, excIn,
	input memOkE memDataOk,
	output logic [`EX1_CMD_W-1:0] opUCmdOut,
	output logic [1:0] exHold,
	output logic [`EX1_REGID_W-1:0] regIdRn1,
	output logic [`EX1_DATA_W-1:0] regValRn1,
	output logic [`EX1_REGID_W-1:0] regIdCn1,
	output logic [`EX1_DATA_W-1:0] regValCn1,
	output logic [`EX1_REGID_W-1:0] heldIdRn1,
	output logic [`EX1_DATA_W-1:0] srOut, lrOut,
	output logic [`EX1_VADDR_W-1:0] memAddr,
	output logic [4:0] memOpm,
	output logic [`EX1_DATA_W-1:0] memDataOut,
	output logic trapValid,
	output logic [`EX1_TRAP_W-1:0] trapOut
);
	logic [`EX1_VADDR_W-1:0] aguAddr;
	logic [`EX1_DATA_W-1:0] aguTarget;

	ex1OperandIf ops (.clock(clock));
	ex1ResultIf braRes ();
	ex1ResultIf sysRes ();

	// operands, uCmd comes back from dispatch
	assign ops.ixt = opUIxt[`EX1_OPC_W-1:0];
	assign ops.idRs = regIdRs;
	assign ops.idRt = regIdRt;
	assign ops.idRm = regIdRm;
	assign ops.valRs = regValRs;
	assign ops.valRt = regValRt;
	assign ops.valRm = regValRm;
	assign ops.pc = pc;
	assign ops.basePc = basePc;
	assign ops.srT = srIn[0];
	assign ops.srS = srIn[1];
	assign ops.srJq = srIn[`EX1_JQ_SR_BIT];

	ex1Agu u_agu (.clock(clock), .rst(rst), .ops(ops), .memAddr(aguAddr),
		.braTarget(aguTarget));

	ex1BranchUnit u_braUnit (.ops(ops), .aguTarget(aguTarget), .preBra(preBra),
		.res(braRes));

	// exception bit 15 masks BREAK
	ex1SysOps u_sysOps (.ops(ops), .excInhibit(excIn[15]), .dlrLow(dlrIn[11:0]),
		.res(sysRes));

	ex1Dispatch u_dispatch (.opUCmd(opUCmd), .opUIxt(opUIxt), .braFlush(braFlush),
		.srIn(srIn), .lrIn(lrIn), .memDataOk(memDataOk), .memAddrIn(aguAddr),
		.ops(ops), .bra(braRes), .sys(sysRes), .opUCmdOut(opUCmdOut), .exHold(exHold),
		.regIdRn1(regIdRn1), .regValRn1(regValRn1), .regIdCn1(regIdCn1),
		.regValCn1(regValCn1), .heldIdRn1(heldIdRn1), .srOut(srOut), .lrOut(lrOut),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.trapValid(trapValid), .trapOut(trapOut));

endmodule

`default_nettype wire

// File: design/ex1SysOps.sv
/* OP_IXS / OP_IXT sub-ops of EX1: sr flag ops, MOVT family, traps,
   BREAK and the TLB / trap memory requests */
`timescale 1ns/1ns
`default_nettype none
`include "ex1_cfg.svh"

module ex1SysOps import ex1Pkg::*; (
	ex1OperandIf.reader ops,
	input logic excInhibit,
	input logic [11:0] dlrLow,
	ex1ResultIf.unit res
);
	always_comb begin
		res.claim = 1'b0;
		res.resultValid = 1'b0;
		res.resultValue = '0;
		res.srWrite = 1'b0;
		res.srValue = {ops.srS, ops.srT};
		res.trapValid = 1'b0;
		res.trapCode = TRAP_RTE;
		res.memReq = 1'b0;
		res.memOpm = OPM_READY;
		res.hold = 1'b0;
		if (ops.uCmd == UCMD_OP_IXS) begin
			res.claim = 1'b1;
			case (ixsE'(ops.ixt))
				IXS_NOP: begin
				end
				IXS_MOVT: begin
					res.resultValid = 1'b1;
					res.resultValue[0] = ops.srT;
				end
				IXS_MOVNT: begin
					res.resultValid = 1'b1;
					res.resultValue[0] = !ops.srT;
				end
				IXS_MOVST: begin
					res.resultValid = 1'b1;
					res.resultValue[1:0] = {ops.srS, ops.srT};
				end
				IXS_TRAPB: begin
					res.memReq = 1'b1;
					res.memOpm = OPM_TRAP;
				end
				default: begin
					// unknown sub-op, stall here
					res.claim = 1'b0;
					res.hold = 1'b1;
				end
			endcase
		end else if (ops.uCmd == UCMD_OP_IXT) begin
			res.claim = 1'b1;
			case (ixtE'(ops.ixt))
				IXT_NOP, IXT_SLEEP: begin
				end
				// parks the pipe unless exceptions are masked
				IXT_BREAK: res.hold = !excInhibit;
				IXT_CLRT: begin
					res.srWrite = 1'b1;
					res.srValue[0] = 1'b0;
				end
				IXT_SETT: begin
					res.srWrite = 1'b1;
					res.srValue[0] = 1'b1;
				end
				IXT_CLRS: begin
					res.srWrite = 1'b1;
					res.srValue[1] = 1'b0;
				end
				IXT_SETS: begin
					res.srWrite = 1'b1;
					res.srValue[1] = 1'b1;
				end
				IXT_NOTT: begin
					res.srWrite = 1'b1;
					res.srValue[0] = !ops.srT;
				end
				IXT_NOTS: begin
					res.srWrite = 1'b1;
					res.srValue[1] = !ops.srS;
				end
				IXT_RTE: res.trapValid = 1'b1;
				IXT_TRAPA: begin
					// trap number rides in the Rm id field
					res.trapValid = 1'b1;
					res.trapCode = TRAP_TRAPA | {12'h000, ops.idRm[3:0]};
				end
				IXT_SYSE: begin
					res.trapValid = 1'b1;
					res.trapCode = TRAP_SYSE | {4'h0, dlrLow};
				end
				IXT_LDTLB: begin
					res.memReq = 1'b1;
					res.memOpm = OPM_LDTLB;
				end
				IXT_INVTLB: begin
					res.memReq = 1'b1;
					res.memOpm = OPM_INVTLB;
				end
				default: begin
					res.claim = 1'b0;
					res.hold = 1'b1;
				end
			endcase
		end
	end

	// never redirects or touches LR
	assign res.doBra = 1'b0;
	assign res.braTarget = ops.pc;
	assign res.lrWrite = 1'b0;
	assign res.lrValue = '0;

endmodule

`default_nettype wire

// File: include/ex1_cfg.svh
/* width and field settings for the EX1 execute stage
   pulled in by the package, the interfaces and every RTL module */
`ifndef EX1_CFG_SVH
`define EX1_CFG_SVH

// register data and virtual address
`define EX1_DATA_W 64
`define EX1_VADDR_W 48

// branch add without jump-quad stops here
`define EX1_LOW_W 32

`define EX1_REGID_W 6

// command byte is cc plus opcode
`define EX1_CMD_W 8
`define EX1_OPC_W 6

// trap word, base pc above a 16-bit code
`define EX1_TRAP_W 64
`define EX1_TRAPC_W 16

// sr bit that arms the jump-quad flag
`define EX1_JQ_SR_BIT 31

`endif

// File: sim/ex1Tb.sv
/* self-checking testbench for ex1Stage, random micro-ops in five test groups
   outputs are compared every cycle with a reference model at the falling edge */
`timescale 1ns/1ns
`default_nettype none
`include "ex1_cfg.svh"

module ex1Tb import ex1Pkg::*; ();
	localparam int RST_CYCLES = 8;
	localparam int N_PRED = 48;
	localparam int N_MEM = 32;
	localparam int N_BRA = 60;
	localparam int N_RES = 40;
	localparam int N_SYS = 44;
	localparam int N_STIM = N_PRED + N_MEM + N_BRA + N_RES + N_SYS;
	// 20 cycles per stimulus plus reset and drain
	localparam int LIMIT_CYCLES = N_STIM * 20 + RST_CYCLES + 4;

	// expected stage outputs
	typedef struct packed {
		logic [`EX1_CMD_W-1:0] cmdOut;
		logic [1:0] hold;
		logic [`EX1_REGID_W-1:0] idRn1;
		logic [`EX1_DATA_W-1:0] valRn1;
		logic [`EX1_REGID_W-1:0] idCn1;
		logic [`EX1_DATA_W-1:0] valCn1;
		logic [`EX1_REGID_W-1:0] heldId;
		logic [`EX1_DATA_W-1:0] sr;
		logic [`EX1_DATA_W-1:0] lr;
		logic [`EX1_VADDR_W-1:0] addr;
		logic [4:0] opm;
		logic [`EX1_DATA_W-1:0] memData;
		logic trapValid;
		logic [`EX1_TRAP_W-1:0] trap;
	} expT;

	logic clock, rst;
	logic [`EX1_CMD_W-1:0] opUCmd, opUIxt;
	preBraE preBra;
	logic braFlush;
	logic [`EX1_REGID_W-1:0] regIdRs, regIdRt, regIdRm;
	logic [`EX1_DATA_W-1:0] regValRs, regValRt, regValRm, pc;
	logic [`EX1_VADDR_W-1:0] basePc;
	logic [`EX1_DATA_W-1:0] srIn, lrIn, dlrIn, excIn;
	memOkE memDataOk;
	logic [`EX1_CMD_W-1:0] opUCmdOut;
	logic [1:0] exHold;
	logic [`EX1_REGID_W-1:0] regIdRn1, regIdCn1, heldIdRn1;
	logic [`EX1_DATA_W-1:0] regValRn1, regValCn1, srOut, lrOut, memDataOut;
	logic [`EX1_VADDR_W-1:0] memAddr;
	logic [4:0] memOpm;
	logic trapValid;
	logic [`EX1_TRAP_W-1:0] trapOut;
	logic checkEn;
	// model of the jump-quad flag
	logic jqModel;
	expT expected;

	ex1Stage u_ex1Stage (.clock(clock), .rst(rst), .opUCmd(opUCmd), .opUIxt(opUIxt),
		.preBra(preBra), .braFlush(braFlush), .regIdRs(regIdRs), .regIdRt(regIdRt),
		.regIdRm(regIdRm), .regValRs(regValRs), .regValRt(regValRt), .regValRm(regValRm),
		.pc(pc), .basePc(basePc), .srIn(srIn), .lrIn(lrIn), .dlrIn(dlrIn), .excIn(excIn),
		.memDataOk(memDataOk), .opUCmdOut(opUCmdOut), .exHold(exHold),
		.regIdRn1(regIdRn1), .regValRn1(regValRn1), .regIdCn1(regIdCn1),
		.regValCn1(regValCn1), .heldIdRn1(heldIdRn1), .srOut(srOut), .lrOut(lrOut),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.trapValid(trapValid), .trapOut(trapOut));

	// expected outputs from the current inputs and last cycle's sr bit 31
	function automatic expT ex1Ref(input logic jq);
		expT e;
		logic en;
		logic [5:0] opc, eff, sub;
		logic [63:0] sum, disp, full, target;
		logic [31:0] low;
		logic issue;
		opc = opUCmd[5:0];
		sub = opUIxt[5:0];
		case (opUCmd[7:6])
			2'd0: en = 1'b1;
			2'd1: en = 1'b0;
			2'd2: en = srIn[0];
			default: en = !srIn[0];
		endcase
		en = en && !braFlush;
		if (en) begin
			eff = opc;
		end else if (opc == UCMD_BRA && !braFlush) begin
			eff = UCMD_BRA_NB;
		end else begin
			eff = UCMD_NOP;
		end
		// displacement in halfwords, upper add only with jump-quad
		disp = regValRt << 1;
		full = pc + disp;
		low = pc[31:0] + disp[31:0];
		target = jq ? {pc[63:48], full[47:0]} : {pc[63:32], low};
		sum = regValRs + (regValRt << opUIxt[5:4]);
		e = '0;
		e.cmdOut = {2'b00, eff};
		e.idRn1 = REG_ZZR;
		e.idCn1 = REG_ZZR;
		e.heldId = REG_ZZR;
		e.sr = srIn;
		e.lr = lrIn;
		e.addr = sum[47:0];
		e.opm = OPM_READY;
		e.memData = regValRm;
		issue = 1'b0;
		case (eff)
			UCMD_NOP: begin
			end
			UCMD_INVOP: begin
				e.trapValid = 1'b1;
				e.trap = {basePc, 16'h800E};
			end
			UCMD_LEA_MR: begin
				e.idRn1 = regIdRm;
				e.valRn1 = {16'h0, sum[47:0]};
			end
			UCMD_MOV_RM: begin
				e.opm = {2'b10, opUIxt[2], opUIxt[5:4]};
				issue = 1'b1;
			end
			UCMD_MOV_MR: begin
				e.opm = {2'b01, opUIxt[2], opUIxt[5:4]};
				issue = 1'b1;
				e.hold[1] = 1'b1;
				e.heldId = regIdRm;
			end
			UCMD_ALU3, UCMD_MUL3, UCMD_CONV_RR: begin
				e.hold[1] = 1'b1;
				e.heldId = regIdRm;
			end
			UCMD_MOV_CR: begin
				e.idRn1 = regIdRm;
				e.valRn1 = regValRs;
			end
			UCMD_MOV_RC: begin
				e.idRn1 = regIdRm;
				e.valRn1 = regValRs;
				e.idCn1 = regIdRm;
				e.valCn1 = regValRs;
				if (regIdRm == REG_LR) begin
					e.lr = regValRs;
				end
			end
			UCMD_MOV_IR: begin
				e.idRn1 = regIdRm;
				// shifted loads append the immediate below the old value
				case (opUIxt[3:0])
					4'h1: e.valRn1 = (regValRs << 8) | {56'h0, regValRt[7:0]};
					4'h2: e.valRn1 = (regValRs << 16) | {48'h0, regValRt[15:0]};
					4'h3: e.valRn1 = (regValRs << 32) | {32'h0, regValRt[31:0]};
					default: e.valRn1 = regValRt;
				endcase
			end
			UCMD_BRA_NB: begin
				if (preBra != PRE_NONE) begin
					e.idCn1 = REG_PC;
					e.valCn1 = pc;
				end
			end
			UCMD_BRA, UCMD_BSR, UCMD_JMP: begin
				if (preBra != PRE_TAKEN) begin
					e.idCn1 = REG_PC;
					e.valCn1 = (eff == UCMD_JMP) ? {pc[63:48], regValRs[47:0]} : target;
				end
				if (eff == UCMD_BSR) begin
					e.lr = pc;
				end
			end
			UCMD_JSR: begin
				e.idCn1 = REG_PC;
				e.valCn1 = regValRs;
				e.lr = pc;
			end
			UCMD_OP_IXS: begin
				case (sub)
					IXS_NOP: begin
					end
					IXS_MOVT: e.valRn1 = {63'h0, srIn[0]};
					IXS_MOVNT: e.valRn1 = {63'h0, !srIn[0]};
					IXS_MOVST: e.valRn1 = {62'h0, srIn[1:0]};
					IXS_TRAPB: begin
						e.opm = 5'b11001;
						issue = 1'b1;
					end
					default: e.hold[0] = 1'b1;
				endcase
				if (sub == IXS_MOVT || sub == IXS_MOVNT || sub == IXS_MOVST) begin
					e.idRn1 = regIdRm;
				end
			end
			UCMD_OP_IXT: begin
				case (sub)
					IXT_NOP, IXT_SLEEP: begin
					end
					IXT_BREAK: e.hold[0] = !excIn[15];
					IXT_CLRT: e.sr[0] = 1'b0;
					IXT_SETT: e.sr[0] = 1'b1;
					IXT_CLRS: e.sr[1] = 1'b0;
					IXT_SETS: e.sr[1] = 1'b1;
					IXT_NOTT: e.sr[0] = !srIn[0];
					IXT_NOTS: e.sr[1] = !srIn[1];
					IXT_RTE: e.trap = {basePc, 16'hFF00};
					IXT_TRAPA: e.trap = {basePc, 16'hC080 | {12'h0, regIdRm[3:0]}};
					IXT_SYSE: e.trap = {basePc, 16'hE000 | {4'h0, dlrIn[11:0]}};
					IXT_LDTLB: e.opm = 5'b11010;
					IXT_INVTLB: e.opm = 5'b11011;
					default: e.hold[0] = 1'b1;
				endcase
				e.trapValid = (sub == IXT_RTE || sub == IXT_TRAPA || sub == IXT_SYSE);
				issue = (sub == IXT_LDTLB || sub == IXT_INVTLB);
			end
			// nobody claims this opcode
			default: e.hold[0] = 1'b1;
		endcase
		if (issue && memDataOk == MEM_HOLD) begin
			e.hold[0] = 1'b1;
		end
		if (braFlush) begin
			e.idRn1 = REG_ZZR;
			e.idCn1 = REG_ZZR;
		end
		return e;
	endfunction

	task automatic checkEq(input string what, input logic [63:0] gotVal,
		input logic [63:0] expVal);
		if (gotVal !== expVal) begin
			$display("Mismatch at %0t ns: %s got 0x%h, expected 0x%h", $time, what,
				gotVal, expVal);
			$display("** FAIL **");
			$fatal(1, "output check failed");
		end
	endtask

	// compare in the middle of the cycle, inputs changed at the rising edge
	always @(negedge clock) begin
		if (checkEn) begin
			expected = ex1Ref(jqModel);
			checkEq("opUCmdOut", 64'(opUCmdOut), 64'(expected.cmdOut));
			checkEq("exHold", 64'(exHold), 64'(expected.hold));
			checkEq("regIdRn1", 64'(regIdRn1), 64'(expected.idRn1));
			if (expected.idRn1 != REG_ZZR) begin
				checkEq("regValRn1", regValRn1, expected.valRn1);
			end
			checkEq("regIdCn1", 64'(regIdCn1), 64'(expected.idCn1));
			if (expected.idCn1 != REG_ZZR) begin
				checkEq("regValCn1", regValCn1, expected.valCn1);
			end
			checkEq("heldIdRn1", 64'(heldIdRn1), 64'(expected.heldId));
			checkEq("srOut", srOut, expected.sr);
			checkEq("lrOut", lrOut, expected.lr);
			checkEq("memAddr", 64'(memAddr), 64'(expected.addr));
			checkEq("memOpm", 64'(memOpm), 64'(expected.opm));
			// store data only matters on a store
			if (expected.opm[4:3] == 2'b10) begin
				checkEq("memDataOut", memDataOut, expected.memData);
			end
			checkEq("trapValid", 64'(trapValid), 64'(expected.trapValid));
			if (expected.trapValid) begin
				checkEq("trapOut", trapOut, expected.trap);
			end
		end
	end

	// flag follows sr bit 31 one cycle late, cleared by reset
	always @(posedge clock) begin
		if (rst) begin
			jqModel <= 1'b0;
		end else begin
			jqModel <= srIn[31];
		end
	end

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#(LIMIT_CYCLES * 10);
		$display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	// fresh random operands, called right after a rising edge
	task automatic randOperands();
		regIdRs <= 6'($urandom);
		regIdRt <= 6'($urandom);
		regIdRm <= 6'($urandom);
		regValRs <= {$urandom, $urandom};
		regValRt <= {$urandom, $urandom};
		regValRm <= {$urandom, $urandom};
		pc <= {$urandom, $urandom};
		basePc <= 48'({$urandom, $urandom});
		srIn <= {$urandom, $urandom};
		lrIn <= {$urandom, $urandom};
		dlrIn <= {$urandom, $urandom};
		excIn <= {$urandom, $urandom};
	endtask

	task automatic driveIdle();
		@(posedge clock);
		opUCmd <= {CC_AL, UCMD_NOP};
		opUIxt <= '0;
		braFlush <= 1'b0;
		preBra <= PRE_NONE;
		memDataOk <= MEM_OK;
	endtask

	// BRA and LDI under random conditions, SR.T and flush
	task automatic predicateOps();
		logic [5:0] opc;
		for (int i = 0; i < N_PRED; i++) begin
			opc = (i % 2 == 0) ? UCMD_BRA : UCMD_MOV_IR;
			@(posedge clock);
			randOperands();
			opUCmd <= {2'($urandom), opc};
			opUIxt <= 8'($urandom);
			braFlush <= 1'($urandom);
			preBra <= preBraE'(2'($urandom % 3));
			memDataOk <= MEM_OK;
		end
	endtask

	// loads and stores, HOLD for a few cycles with inputs kept stable
	task automatic issueMemOps();
		logic [5:0] opc;
		int waitCycles;
		for (int i = 0; i < N_MEM; i++) begin
			opc = (i % 2 == 0) ? UCMD_MOV_RM : UCMD_MOV_MR;
			waitCycles = int'($urandom % 4);
			@(posedge clock);
			randOperands();
			opUCmd <= {CC_AL, opc};
			opUIxt <= 8'($urandom);
			braFlush <= 1'b0;
			preBra <= PRE_NONE;
			memDataOk <= (waitCycles > 0) ? MEM_HOLD : MEM_OK;
			if (waitCycles > 0) begin
				repeat (waitCycles) @(posedge clock);
				memDataOk <= MEM_OK;
			end
			// stage releases hold once memory answers OK
			@(negedge clock);
			while (exHold[0] !== 1'b0) @(negedge clock);
		end
	endtask

	// every branch kind against every prediction, sr bit 31 toggling
	task automatic resolveBranches();
		logic [5:0] opc;
		for (int i = 0; i < N_BRA; i++) begin
			case (i % 5)
				0: opc = UCMD_BRA;
				1: opc = UCMD_BSR;
				2: opc = UCMD_JMP;
				3: opc = UCMD_JSR;
				default: opc = UCMD_BRA_NB;
			endcase
			@(posedge clock);
			randOperands();
			srIn[31] <= 1'((i / 3) % 2);
			opUCmd <= {CC_AL, opc};
			opUIxt <= 8'($urandom);
			braFlush <= 1'b0;
			preBra <= preBraE'(2'((i / 5) % 3));
			memDataOk <= MEM_OK;
		end
	endtask

	// single-cycle results into Rm, multi-cycle ops marked held
	task automatic forwardResults();
		logic [5:0] opc;
		for (int i = 0; i < N_RES; i++) begin
			case (i % 10)
				0: opc = UCMD_LEA_MR;
				1, 2, 3, 9: opc = UCMD_MOV_IR;
				4: opc = UCMD_MOV_RC;
				5: opc = UCMD_MOV_CR;
				6: opc = UCMD_ALU3;
				7: opc = UCMD_MUL3;
				default: opc = UCMD_CONV_RR;
			endcase
			@(posedge clock);
			randOperands();
			if (i % 20 == 4) begin
				regIdRm <= REG_LR;
			end
			opUCmd <= {CC_AL, opc};
			// low nibble picks LDI or the shifted loads
			opUIxt <= {4'($urandom), 4'(i % 10)};
			braFlush <= 1'b0;
			preBra <= PRE_NONE;
			memDataOk <= MEM_OK;
		end
	endtask

	// all IXS and IXT sub-ops, one unknown each, then INVOP and a bad opcode
	task automatic decodeSysOps();
		logic [5:0] opc;
		logic [5:0] sub;
		for (int i = 0; i < N_SYS; i++) begin
			sub = 6'($urandom);
			if (i < 12) begin
				opc = UCMD_OP_IXS;
				sub = (i % 6 == 5) ? {2'b10, sub[3:0]} : 6'(i % 6);
			end else if (i < 42) begin
				opc = UCMD_OP_IXT;
				sub = ((i - 12) % 15 == 14) ? {2'b11, sub[3:0]} : 6'((i - 12) % 15);
			end else begin
				opc = (i == 42) ? UCMD_INVOP : 6'h3A;
			end
			@(posedge clock);
			randOperands();
			// BREAK lands once with bit 15 clear and once set
			excIn[15] <= 1'(i % 2);
			opUCmd <= {CC_AL, opc};
			opUIxt <= {2'($urandom), sub};
			braFlush <= 1'b0;
			preBra <= PRE_NONE;
			memDataOk <= MEM_OK;
		end
	endtask

	initial begin
		void'($urandom(25));
		rst = 1'b1;
		checkEn = 1'b0;
		opUCmd = '0;
		opUIxt = '0;
		preBra = PRE_NONE;
		braFlush = 1'b0;
		regIdRs = '0;
		regIdRt = '0;
		regIdRm = '0;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		pc = '0;
		basePc = '0;
		srIn = '0;
		lrIn = '0;
		dlrIn = '0;
		excIn = '0;
		memDataOk = MEM_OK;
		repeat (RST_CYCLES) @(posedge clock);
		rst <= 1'b0;
		// first checked cycle is the idle NOP after reset
		checkEn <= 1'b1;
		predicateOps();
		issueMemOps();
		resolveBranches();
		forwardResults();
		decodeSysOps();
		driveIdle();
		@(posedge clock);
		@(posedge clock);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
design/ex1Pkg.sv
design/ex1Ifs.sv
design/ex1Agu.sv
design/ex1BranchUnit.sv
design/ex1SysOps.sv
design/ex1Dispatch.sv
design/ex1Stage.sv
sim/ex1Tb.sv
